//--- source/mips_decode_pkg.sv
package mips_decode_pkg;

    // primary opcodes, only the kept subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FUN_SLL     = 6'h00,
        FUN_SRL     = 6'h02,
        FUN_SRA     = 6'h03,
        FUN_SLLV    = 6'h04,
        FUN_SRLV    = 6'h06,
        FUN_SRAV    = 6'h07,
        FUN_JR      = 6'h08,
        FUN_JALR    = 6'h09,
        FUN_SYSCALL = 6'h0c,
        FUN_BREAK   = 6'h0d,
        FUN_SYNC    = 6'h0f,
        FUN_ADD     = 6'h20,
        FUN_ADDU    = 6'h21,
        FUN_SUB     = 6'h22,
        FUN_SUBU    = 6'h23,
        FUN_AND     = 6'h24,
        FUN_OR      = 6'h25,
        FUN_XOR     = 6'h26,
        FUN_NOR     = 6'h27,
        FUN_SLT     = 6'h2a,
        FUN_SLTU    = 6'h2b
    } funct_e;

    // rt field under REGIMM
    typedef enum logic [4:0] {
        RT_BLTZ   = 5'h00,
        RT_BGEZ   = 5'h01,
        RT_BLTZAL = 5'h10,
        RT_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLL, ALU_SLLV,
        ALU_SRL, ALU_SRLV, ALU_SRA, ALU_SRAV, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BT_NONE, BT_JREG, BT_J, BT_BEQ, BT_BNE, BT_BGTZ, BT_BLEZ, BT_BGEZ, BT_BLTZ
    } branch_type_e;

    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} dest_sel_e;

    typedef enum logic [2:0] {
        EXC_NONE, EXC_SYSCALL, EXC_BREAK, EXC_ERET, EXC_UNDEFINED
    } exc_e;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
        logic [15:0] imm;
        logic [31:0] imm_ext;
        logic [25:0] j_target;
        logic        is_eret;
    } instr_fields_t;

    typedef struct packed {
        alu_op_e      aluop;
        logic         alu_sela;   // shamt as operand a
        logic         alu_selb;   // imm_ext as operand b
        logic         mem_en;
        logic         mem_read;
        logic         mem_write;
        logic         mem_to_reg;
        logic         reg_wen;
        dest_sel_e    dest_sel;
        branch_type_e branch_type;
        logic         link_pc8;
        exc_e         exc;
    } ctrl_t;

    typedef struct packed {
        instr_fields_t fields;
        ctrl_t         ctrl;
        logic [4:0]    reg_waddr;
    } decoded_t;

    localparam logic [4:0]  LINK_REG  = 5'd31;
    localparam logic [31:0] ERET_WORD = 32'h4200_0018;

    localparam ctrl_t CTRL_NOP = '{
        aluop:       ALU_NOP,
        dest_sel:    DEST_RD,
        branch_type: BT_NONE,
        exc:         EXC_NONE,
        default:     1'b0
    };

endpackage

//--- source/field_split_stage.sv
module field_split_stage
    import mips_decode_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          in_valid,
    input  logic [31:0]   instr,
    output logic          out_valid,
    output instr_fields_t fields
);

    instr_fields_t fields_d;
    logic          zero_ext;

    // op[3:2] == 2'b11 covers the logic immediates and LUI
    assign zero_ext = (instr[29:28] == 2'b11);

    always_comb begin
        fields_d.op       = instr[31:26];
        fields_d.rs       = instr[25:21];
        fields_d.rt       = instr[20:16];
        fields_d.rd       = instr[15:11];
        fields_d.shamt    = instr[10:6];
        fields_d.funct    = instr[5:0];
        fields_d.imm      = instr[15:0];
        fields_d.j_target = instr[25:0];
        if (zero_ext) begin
            fields_d.imm_ext = {16'h0000, instr[15:0]};
        end else begin
            fields_d.imm_ext = {{16{instr[15]}}, instr[15:0]};
        end
        fields_d.is_eret  = (instr == ERET_WORD);  // whole word must match
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // data only moves with a valid word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fields <= '0;
        end else if (in_valid) begin
            fields <= fields_d;
        end
    end

endmodule

//--- source/control_decode_stage.sv
module control_decode_stage
    import mips_decode_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          in_valid,
    input  instr_fields_t in_fields,
    output logic          out_valid,
    output instr_fields_t out_fields,
    output ctrl_t         ctrl
);

    ctrl_t ctrl_d;

    always_comb begin
        ctrl_d = CTRL_NOP;
        case (in_fields.op)
            OP_SPECIAL: begin
                ctrl_d.reg_wen  = 1'b1;
                ctrl_d.dest_sel = DEST_RD;
                case (in_fields.funct)
                    FUN_AND:  ctrl_d.aluop = ALU_AND;
                    FUN_OR:   ctrl_d.aluop = ALU_OR;
                    FUN_XOR:  ctrl_d.aluop = ALU_XOR;
                    FUN_NOR:  ctrl_d.aluop = ALU_NOR;
                    FUN_SLT:  ctrl_d.aluop = ALU_SLT;
                    FUN_SLTU: ctrl_d.aluop = ALU_SLTU;
                    FUN_ADD:  ctrl_d.aluop = ALU_ADD;
                    FUN_ADDU: ctrl_d.aluop = ALU_ADDU;
                    FUN_SUB:  ctrl_d.aluop = ALU_SUB;
                    FUN_SUBU: ctrl_d.aluop = ALU_SUBU;
                    FUN_SLLV: ctrl_d.aluop = ALU_SLLV;
                    FUN_SRLV: ctrl_d.aluop = ALU_SRLV;
                    FUN_SRAV: ctrl_d.aluop = ALU_SRAV;
                    FUN_SLL: begin
                        ctrl_d.aluop    = ALU_SLL;
                        ctrl_d.alu_sela = 1'b1;
                    end
                    FUN_SRL: begin
                        ctrl_d.aluop    = ALU_SRL;
                        ctrl_d.alu_sela = 1'b1;
                    end
                    FUN_SRA: begin
                        ctrl_d.aluop    = ALU_SRA;
                        ctrl_d.alu_sela = 1'b1;
                    end
                    FUN_JR: begin
                        ctrl_d.reg_wen     = 1'b0;
                        ctrl_d.branch_type = BT_JREG;
                    end
                    FUN_JALR: begin  // rd gets pc+8
                        ctrl_d.branch_type = BT_JREG;
                        ctrl_d.link_pc8    = 1'b1;
                    end
                    FUN_SYSCALL: begin
                        ctrl_d.reg_wen = 1'b0;
                        ctrl_d.exc     = EXC_SYSCALL;
                    end
                    FUN_BREAK: begin
                        ctrl_d.reg_wen = 1'b0;
                        ctrl_d.exc     = EXC_BREAK;
                    end
                    FUN_SYNC: ctrl_d = CTRL_NOP;  // no-op here
                    default: begin
                        ctrl_d     = CTRL_NOP;
                        ctrl_d.exc = EXC_UNDEFINED;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_d.alu_selb = 1'b1;
                ctrl_d.reg_wen  = 1'b1;
                ctrl_d.dest_sel = DEST_RT;
                case (in_fields.op)
                    OP_ADDI:  ctrl_d.aluop = ALU_ADD;
                    OP_ADDIU: ctrl_d.aluop = ALU_ADDU;
                    OP_SLTI:  ctrl_d.aluop = ALU_SLT;
                    OP_SLTIU: ctrl_d.aluop = ALU_SLTU;
                    OP_ANDI:  ctrl_d.aluop = ALU_AND;
                    OP_ORI:   ctrl_d.aluop = ALU_OR;
                    OP_XORI:  ctrl_d.aluop = ALU_XOR;
                    default:  ctrl_d.aluop = ALU_LUI;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                ctrl_d.aluop      = ALU_ADDU;  // base + offset
                ctrl_d.alu_selb   = 1'b1;
                ctrl_d.mem_en     = 1'b1;
                ctrl_d.mem_read   = 1'b1;
                ctrl_d.mem_to_reg = 1'b1;
                ctrl_d.reg_wen    = 1'b1;
                ctrl_d.dest_sel   = DEST_RT;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl_d.aluop     = ALU_ADDU;
                ctrl_d.alu_selb  = 1'b1;
                ctrl_d.mem_en    = 1'b1;
                ctrl_d.mem_write = 1'b1;
            end
            OP_J:   ctrl_d.branch_type = BT_J;
            OP_JAL: begin
                ctrl_d.branch_type = BT_J;
                ctrl_d.link_pc8    = 1'b1;
                ctrl_d.reg_wen     = 1'b1;
                ctrl_d.dest_sel    = DEST_LINK;
            end
            OP_BEQ:  ctrl_d.branch_type = BT_BEQ;
            OP_BNE:  ctrl_d.branch_type = BT_BNE;
            OP_BGTZ: ctrl_d.branch_type = BT_BGTZ;
            OP_BLEZ: ctrl_d.branch_type = BT_BLEZ;
            OP_REGIMM: begin
                case (in_fields.rt)
                    RT_BGEZ: ctrl_d.branch_type = BT_BGEZ;
                    RT_BLTZ: ctrl_d.branch_type = BT_BLTZ;
                    RT_BGEZAL, RT_BLTZAL: begin
                        // link forms write pc+8 to r31
                        ctrl_d.branch_type = (in_fields.rt == RT_BGEZAL) ? BT_BGEZ : BT_BLTZ;
                        ctrl_d.link_pc8    = 1'b1;
                        ctrl_d.reg_wen     = 1'b1;
                        ctrl_d.dest_sel    = DEST_LINK;
                    end
                    default: ctrl_d = CTRL_NOP;
                endcase
            end
            default: ctrl_d.exc = EXC_UNDEFINED;  // ERET lands here too
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_fields <= '0;
            ctrl       <= CTRL_NOP;
        end else if (in_valid) begin
            out_fields <= in_fields;
            ctrl       <= ctrl_d;
        end
    end

endmodule

//--- source/dest_resolve_stage.sv
module dest_resolve_stage
    import mips_decode_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          in_valid,
    input  instr_fields_t in_fields,
    input  ctrl_t         in_ctrl,
    output logic          out_valid,
    output decoded_t      out
);

    logic [4:0] waddr;
    ctrl_t      ctrl_d;

    always_comb begin
        case (in_ctrl.dest_sel)
            DEST_RT:   waddr = in_fields.rt;
            DEST_LINK: waddr = LINK_REG;
            default:   waddr = in_fields.rd;
        endcase
    end

    always_comb begin
        ctrl_d = in_ctrl;
        // r0 is hardwired, never report a write to it
        ctrl_d.reg_wen = in_ctrl.reg_wen && (waddr != 5'd0);

        // COP0 opcode was flagged undefined in stage 2
        if (in_fields.is_eret) begin
            ctrl_d.exc = EXC_ERET;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out.fields    <= '0;
            out.ctrl      <= CTRL_NOP;
            out.reg_waddr <= 5'd0;
        end else if (in_valid) begin
            out.fields    <= in_fields;
            out.ctrl      <= ctrl_d;
            out.reg_waddr <= waddr;
        end
    end

endmodule

//--- source/instr_decode_pipe.sv
module instr_decode_pipe
    import mips_decode_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        out_valid,
    output decoded_t    out
);

    logic          s1_valid;
    instr_fields_t s1_fields;
    logic          s2_valid;
    instr_fields_t s2_fields;
    ctrl_t         s2_ctrl;

    // split fields, extend imm
    field_split_stage field_split_stage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (instr_valid),
        .instr     (instr),
        .out_valid (s1_valid),
        .fields    (s1_fields)
    );

    control_decode_stage control_decode_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (s1_valid),
        .in_fields  (s1_fields),
        .out_valid  (s2_valid),
        .out_fields (s2_fields),
        .ctrl       (s2_ctrl)
    );

    // waddr, r0 qualify, eret
    dest_resolve_stage dest_resolve_stage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (s2_valid),
        .in_fields (s2_fields),
        .in_ctrl   (s2_ctrl),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

//--- sim/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// ALU op of an R-type ALU funct, ALU_NOP for anything else
function automatic alu_op_e model_rtype_alu(input logic [5:0] fn);
    case (fn)
        FUN_SLL:  return ALU_SLL;
        FUN_SRL:  return ALU_SRL;
        FUN_SRA:  return ALU_SRA;
        FUN_SLLV: return ALU_SLLV;
        FUN_SRLV: return ALU_SRLV;
        FUN_SRAV: return ALU_SRAV;
        FUN_ADD:  return ALU_ADD;
        FUN_ADDU: return ALU_ADDU;
        FUN_SUB:  return ALU_SUB;
        FUN_SUBU: return ALU_SUBU;
        FUN_AND:  return ALU_AND;
        FUN_OR:   return ALU_OR;
        FUN_XOR:  return ALU_XOR;
        FUN_NOR:  return ALU_NOR;
        FUN_SLT:  return ALU_SLT;
        FUN_SLTU: return ALU_SLTU;
        default:  return ALU_NOP;
    endcase
endfunction

function automatic alu_op_e model_imm_alu(input logic [5:0] op);
    case (op)
        OP_ADDI:  return ALU_ADD;
        OP_ADDIU: return ALU_ADDU;
        OP_SLTI:  return ALU_SLT;
        OP_SLTIU: return ALU_SLTU;
        OP_ANDI:  return ALU_AND;
        OP_ORI:   return ALU_OR;
        OP_XORI:  return ALU_XOR;
        OP_LUI:   return ALU_LUI;
        default:  return ALU_NOP;
    endcase
endfunction

function automatic decoded_t decode_model(input logic [31:0] w);
    decoded_t   d;
    ctrl_t      c;
    alu_op_e    a;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rt;
    op = w[31:26];
    fn = w[5:0];
    rt = w[20:16];
    d.fields = '{op: op, rs: w[25:21], rt: rt, rd: w[15:11], shamt: w[10:6], funct: fn,
                 imm: w[15:0], imm_ext: 32'h0, j_target: w[25:0], is_eret: (w == ERET_WORD)};
    // zero extend when op[3:2] is 2'b11
    d.fields.imm_ext = (op[3:2] == 2'b11) ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
    c = CTRL_NOP;
    if (op == OP_SPECIAL) begin
        a = model_rtype_alu(fn);
        if (a != ALU_NOP) begin
            c.aluop    = a;
            c.reg_wen  = 1'b1;
            c.alu_sela = fn inside {FUN_SLL, FUN_SRL, FUN_SRA};
        end else if (fn == FUN_JR) begin
            c.branch_type = BT_JREG;
        end else if (fn == FUN_JALR) begin
            c.branch_type = BT_JREG;
            c.link_pc8    = 1'b1;
            c.reg_wen     = 1'b1;
        end else if (fn == FUN_SYSCALL) begin
            c.exc = EXC_SYSCALL;
        end else if (fn == FUN_BREAK) begin
            c.exc = EXC_BREAK;
        end else if (fn != FUN_SYNC) begin
            c.exc = EXC_UNDEFINED;
        end
    end else if (model_imm_alu(op) != ALU_NOP) begin
        c.aluop    = model_imm_alu(op);
        c.alu_selb = 1'b1;
        c.reg_wen  = 1'b1;
        c.dest_sel = DEST_RT;
    end else if (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}) begin
        c.aluop      = ALU_ADDU;
        c.alu_selb   = 1'b1;
        c.mem_en     = 1'b1;
        c.mem_read   = 1'b1;
        c.mem_to_reg = 1'b1;
        c.reg_wen    = 1'b1;
        c.dest_sel   = DEST_RT;
    end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
        c.aluop     = ALU_ADDU;
        c.alu_selb  = 1'b1;
        c.mem_en    = 1'b1;
        c.mem_write = 1'b1;
    end else if (op == OP_J || op == OP_JAL) begin
        c.branch_type = BT_J;
        if (op == OP_JAL) begin
            c.link_pc8 = 1'b1;
            c.reg_wen  = 1'b1;
            c.dest_sel = DEST_LINK;
        end
    end else if (op == OP_BEQ) c.branch_type = BT_BEQ;
    else if (op == OP_BNE) c.branch_type = BT_BNE;
    else if (op == OP_BGTZ) c.branch_type = BT_BGTZ;
    else if (op == OP_BLEZ) c.branch_type = BT_BLEZ;
    else if (op == OP_REGIMM) begin
        if (rt inside {RT_BGEZ, RT_BGEZAL}) c.branch_type = BT_BGEZ;
        if (rt inside {RT_BLTZ, RT_BLTZAL}) c.branch_type = BT_BLTZ;
        if (rt inside {RT_BGEZAL, RT_BLTZAL}) begin
            c.link_pc8 = 1'b1;
            c.reg_wen  = 1'b1;
            c.dest_sel = DEST_LINK;
        end
    end else begin
        c.exc = EXC_UNDEFINED;
    end
    d.reg_waddr = (c.dest_sel == DEST_RT) ? rt : (c.dest_sel == DEST_LINK) ? 5'd31 : w[15:11];
    if (d.reg_waddr == 5'd0) c.reg_wen = 1'b0;  // r0 never written
    if (d.fields.is_eret) c.exc = EXC_ERET;
    d.ctrl = c;
    return d;
endfunction

`endif

//--- sim/tb_instr_decode_pipe.sv
module tb_instr_decode_pipe
    import mips_decode_pkg::*;
();

    `include "decode_model.svh"

    // directed 17 + 24 + 12 + 5, stream 200
    localparam int num_instr = 258;
    localparam int num_tests = 6;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        out_valid;
    decoded_t    out;

    int       cycle = 0;
    int       errors = 0;
    int       seed = 32'h1423_8dba;
    decoded_t exp_q[$];
    int       due_q[$];
    decoded_t exp_d;
    int       due;

    logic [5:0] op_list [24] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
                                 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                                 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
    logic [5:0] fn_list [21] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
                                 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
                                 6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0f};
    logic [4:0] rt_list [4] = '{5'h00, 5'h01, 5'h10, 5'h11};

    instr_decode_pipe instr_decode_pipe_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .out_valid   (out_valid),
        .out         (out)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic compare_result(input decoded_t e);
        check_val("aluop", e.ctrl.aluop, out.ctrl.aluop);
        check_val("alu_sela", e.ctrl.alu_sela, out.ctrl.alu_sela);
        check_val("alu_selb", e.ctrl.alu_selb, out.ctrl.alu_selb);
        check_val("mem_en", e.ctrl.mem_en, out.ctrl.mem_en);
        check_val("mem_read", e.ctrl.mem_read, out.ctrl.mem_read);
        check_val("mem_write", e.ctrl.mem_write, out.ctrl.mem_write);
        check_val("mem_to_reg", e.ctrl.mem_to_reg, out.ctrl.mem_to_reg);
        check_val("reg_wen", e.ctrl.reg_wen, out.ctrl.reg_wen);
        check_val("branch_type", e.ctrl.branch_type, out.ctrl.branch_type);
        check_val("link_pc8", e.ctrl.link_pc8, out.ctrl.link_pc8);
        check_val("exc", e.ctrl.exc, out.ctrl.exc);
        check_val("reg_waddr", e.reg_waddr, out.reg_waddr);
        check_val("imm_ext", e.fields.imm_ext, out.fields.imm_ext);
        if (e !== out) begin
            errors++;
            $display("[FAIL] %0t out expected %h got %h", $time, e, out);
        end
    endtask

    // result checker, sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("at %0t out_valid rose with no instruction pending", $time);
                end else begin
                    exp_d = exp_q.pop_front();
                    due = due_q.pop_front();
                    if (due != cycle) begin
                        errors++;
                        $display("at %0t result came in cycle %0d instead of %0d",
                                 $time, cycle, due);
                    end
                    compare_result(exp_d);
                end
            end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
                errors++;
                $display("at %0t expected result is missing, out_valid stayed low", $time);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    task automatic send(input logic [31:0] w);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr = w;
        exp_q.push_back(decode_model(w));
        due_q.push_back(cycle + 3);  // sampled next edge, out two edges after that
    endtask

    task automatic end_test(input string name, input int err_before);
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        while (due_q.size() > 0) @(negedge clk);
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (5) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                errors++;
                $display("[FAIL] %0t out_valid expected 0 got %b", $time, out_valid);
            end
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (4) @(negedge clk);  // idle, checker flags any valid
        end_test("reset", e0);
    endtask

    task automatic test_rtype();
        int e0;
        e0 = errors;
        for (int i = 0; i < 16; i++) send(r_word(fn_list[i], 5'd3, 5'd4, 5'(5 + i), 5'(i)));
        send(r_word(FUN_ADDU, 5'd3, 5'd4, 5'd0, 5'd0));
        end_test("rtype", e0);
    endtask

    task automatic test_imm_mem();
        int e0;
        e0 = errors;
        for (int i = 8; i < 16; i++) begin
            send(i_word(op_list[i], 5'd2, 5'd7, 16'h8001));
            send(i_word(op_list[i], 5'd2, 5'd8, 16'h1234));
        end
        for (int i = 16; i < 24; i++) send(i_word(op_list[i], 5'd9, 5'(10 + i), 16'hfff0));
        end_test("imm_mem", e0);
    endtask

    task automatic test_branch();
        int e0;
        e0 = errors;
        send({OP_J, 26'h123_4567});
        send({OP_JAL, 26'h000_0040});
        send(r_word(FUN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
        send(r_word(FUN_JALR, 5'd4, 5'd0, 5'd31, 5'd0));
        send(i_word(OP_BEQ, 5'd1, 5'd2, 16'hfffc));
        send(i_word(OP_BNE, 5'd1, 5'd2, 16'h0010));
        send(i_word(OP_BGTZ, 5'd3, 5'd0, 16'h0008));
        send(i_word(OP_BLEZ, 5'd3, 5'd0, 16'h8000));
        for (int i = 0; i < 4; i++) send(i_word(OP_REGIMM, 5'd6, rt_list[i], 16'h0020));
        end_test("branch", e0);
    endtask

    task automatic test_exceptions();
        int e0;
        e0 = errors;
        send(r_word(FUN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
        send(r_word(FUN_BREAK, 5'd0, 5'd0, 5'd0, 5'd0));
        send(ERET_WORD);
        send(i_word(6'h3f, 5'd1, 5'd2, 16'h0003));
        send(r_word(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0));
        end_test("exceptions", e0);
    endtask

    task automatic test_stream();
        int          e0;
        logic [31:0] r;
        logic [5:0]  op;
        e0 = errors;
        repeat (200) begin
            r = $random(seed);
            op = op_list[{$random(seed)} % 24];
            if (op == OP_SPECIAL) begin
                r[5:0] = fn_list[{$random(seed)} % 21];
            end else if (op == OP_REGIMM) begin
                r[20:16] = rt_list[{$random(seed)} % 4];
            end
            send({op, r[25:0]});
        end
        end_test("stream", e0);
    endtask

    initial begin
        #((num_instr + num_tests * 10 + 50) * 4);
        $display("timeout: the tests did not complete in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = 32'h0;
        test_reset();
        test_rtype();
        test_imm_mem();
        test_branch();
        test_exceptions();
        test_stream();
        $display("tests run %0d, errors %0d", num_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+sim
source/mips_decode_pkg.sv
source/field_split_stage.sv
source/control_decode_stage.sv
source/dest_resolve_stage.sv
source/instr_decode_pipe.sv
sim/tb_instr_decode_pipe.sv
